//--- Makefile
# Verilator build and run of the ccd vertical timing testbench
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_ccd_timing -f project.f
	./obj_dir/Vtb_ccd_timing > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
		echo "test FAILED"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- ccd_readout/ccd_exposure.sv
// exposure controller counting lines after readout and ending on a line end
module ccd_exposure (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic [ccd_pkg::VCNT_W-1:0]  i_exp_lines,
	input  logic                        i_expo_en,
	ccd_timing_if.expo                  tim
);

	// line ends counted so far in this exposure
	logic [ccd_pkg::VCNT_W-1:0] exp_cnt;
	// count value at which the next line end completes exposure
	logic [ccd_pkg::VCNT_W-1:0] exp_last;
	// counting allowed, sensor idle and cycle armed
	logic                       cnt_on;
	logic                       exp_done;

	// zero lines behaves as one line
	assign exp_last = (i_exp_lines == '0) ? '0 : i_exp_lines - 1'b1;
	assign cnt_on = i_expo_en && !tim.readout_flag;

	// >= so a shortened exposure still ends on the next line
	assign exp_done = cnt_on && tim.line_end && (exp_cnt >= exp_last);

	// ----------------------------------------------------------------------
	// exposure line counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			exp_cnt <= '0;
		end else if (!cnt_on) begin
			// held clear during readout or while disarmed
			exp_cnt <= '0;
		end else if (tim.line_end) begin
			if (exp_done) begin
				exp_cnt <= '0;
			end else begin
				exp_cnt <= exp_cnt + 1'b1;
			end
		end
	end

	// shares the cycle with the completing line end
	assign tim.exp_end = exp_done;

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	// exposure end sits on a line end and the sequencer answers it
	a_exp_end_on_line: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		tim.exp_end |-> tim.line_end ##2 tim.readout_flag
	) else $error("exp_end off a line end or not followed by readout");

endmodule

//--- ccd_readout/ccd_readout.sv
// readout sequencer running the xsg and readout phases with the line count
module ccd_readout (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic [ccd_pkg::VCNT_W-1:0]  i_frame_period,
	input  logic                        i_ccd_stop,
	ccd_timing_if.seq                   tim,
	output logic [ccd_pkg::VCNT_W-1:0]  o_vcount
);

	ccd_pkg::seq_state_e state;
	ccd_pkg::seq_state_e state_nxt;

	// stop input one clock late, for edge detect
	logic stop_d;
	logic stop_rise;
	logic xsg_done;
	logic frame_done;

	// ----------------------------------------------------------------------
	// stop edge
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			stop_d <= 1'b0;
		end else begin
			stop_d <= i_ccd_stop;
		end
	end

	assign stop_rise = i_ccd_stop && !stop_d;

	// phase ends
	assign xsg_done = tim.line_end &&
		(o_vcount == ccd_pkg::VCNT_W'(ccd_pkg::XSG_LINE_NUM - 1));
	assign frame_done = tim.line_end && (o_vcount == i_frame_period);

	// ----------------------------------------------------------------------
	// fsm
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ccd_pkg::S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ccd_pkg::S_IDLE: begin
				if (tim.exp_end) begin
					state_nxt = ccd_pkg::S_XSG;
				end
			end
			ccd_pkg::S_XSG: begin
				// stop edge ignored here
				if (xsg_done) begin
					state_nxt = ccd_pkg::S_READOUT;
				end
			end
			ccd_pkg::S_READOUT: begin
				if (frame_done || stop_rise) begin
					state_nxt = ccd_pkg::S_IDLE;
				end
			end
			default: begin
				state_nxt = ccd_pkg::S_IDLE;
			end
		endcase
	end

	// ----------------------------------------------------------------------
	// flags and line count
	// ----------------------------------------------------------------------
	// flags trail the state by one clock
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			tim.xsg_flag     <= 1'b0;
			tim.readout_flag <= 1'b0;
		end else begin
			tim.xsg_flag     <= (state == ccd_pkg::S_XSG);
			tim.readout_flag <= (state != ccd_pkg::S_IDLE);
		end
	end

	// counts lines from the start of xsg through readout
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_vcount <= '0;
		end else if (state == ccd_pkg::S_IDLE) begin
			o_vcount <= '0;
		end else if (tim.line_end) begin
			o_vcount <= o_vcount + 1'b1;
		end
	end

	// xsg ends inside readout after exactly XSG_LINE_NUM line ends
	a_xsg_in_readout: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		$fell(tim.xsg_flag) |-> tim.readout_flag &&
			(o_vcount == ccd_pkg::VCNT_W'(ccd_pkg::XSG_LINE_NUM))
	) else $error("xsg phase left without the programmed line count");

endmodule

//--- common/ccd_pkg.sv
// ccd vertical timing package with shared widths, reset values and enums
package ccd_pkg;

	// ----------------------------------------------------------------------
	// widths
	// ----------------------------------------------------------------------
	// vertical line count and line-count registers
	localparam int VCNT_W = 13;
	// clocks-per-line register
	localparam int LLEN_W = 12;
	// host write data
	localparam int CFG_DATA_W = 16;

	// ----------------------------------------------------------------------
	// sequencer constants
	// ----------------------------------------------------------------------
	// lines held in the transfer-gate phase
	localparam int XSG_LINE_NUM = 2;
	// shortest legal line, shorter values are raised to this
	localparam logic [LLEN_W-1:0] LINE_LEN_MIN = 12'd4;

	// register values after reset
	localparam logic [LLEN_W-1:0] RST_LINE_LEN = 12'd16;
	localparam logic [VCNT_W-1:0] RST_EXP_LINES = 13'd3;
	localparam logic [VCNT_W-1:0] RST_FRAME_PERIOD = 13'd8;

	// ----------------------------------------------------------------------
	// enums
	// ----------------------------------------------------------------------
	// register map of the write port
	typedef enum logic [1:0] {
		REG_LINE_LEN     = 2'd0,
		REG_EXP_LINES    = 2'd1,
		REG_FRAME_PERIOD = 2'd2,
		REG_CTRL         = 2'd3
	} cfg_addr_e;

	// readout sequencer states
	typedef enum logic [1:0] {
		S_IDLE    = 2'd0,
		S_XSG     = 2'd1,
		S_READOUT = 2'd2
	} seq_state_e;

endpackage

//--- common/ccd_timing_if.sv
// line, exposure and sequencer strobes shared between the timing blocks
interface ccd_timing_if;

	// one-cycle strobe at the last clock of every line
	logic line_end;
	// one-cycle strobe, exposure done, always on a line end
	logic exp_end;
	// high from xsg start to the end of readout
	logic readout_flag;
	// high only through the transfer-gate phase
	logic xsg_flag;

	// line timer, source of the line strobe
	modport timer (
		output line_end
	);

	// exposure controller
	// waits for readout to finish before counting
	modport expo (
		input  line_end,
		input  readout_flag,
		output exp_end
	);

	// readout sequencer
	modport seq (
		input  line_end,
		input  exp_end,
		output readout_flag,
		output xsg_flag
	);

endinterface

//--- hw/ccd_line_timer.sv
// line timer dividing the clock into lines of programmable length
module ccd_line_timer (
	input  logic                        clk,
	input  logic                        i_rst_n,
	input  logic [ccd_pkg::LLEN_W-1:0]  i_line_len,
	ccd_timing_if.timer                 tim
);

	// programmed length raised to the minimum
	logic [ccd_pkg::LLEN_W-1:0] len_clamped;
	// length the running line was started with
	logic [ccd_pkg::LLEN_W-1:0] len_q;
	// clock position inside the line
	logic [ccd_pkg::LLEN_W-1:0] cnt;
	logic                       len_change;
	logic                       last_clk;

	assign len_clamped = (i_line_len < ccd_pkg::LINE_LEN_MIN) ?
		ccd_pkg::LINE_LEN_MIN : i_line_len;
	assign len_change = (len_clamped != len_q);
	// cnt and len_q move together, so no stray strobe on a rewrite
	assign last_clk = (cnt == len_q - 1'b1);

	// ----------------------------------------------------------------------
	// line counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			len_q <= ccd_pkg::RST_LINE_LEN;
			cnt   <= '0;
		end else if (len_change) begin
			// new length, restart the line from zero
			len_q <= len_clamped;
			cnt   <= '0;
		end else if (last_clk) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// strobe on the last clock of the line
	assign tim.line_end = last_clk;

endmodule

//--- hw/ccd_regs.sv
// configuration registers written over a four-phase req/ack port
module ccd_regs (
	input  logic                            clk,
	input  logic                            i_rst_n,
	input  logic                            i_cfg_req,
	input  ccd_pkg::cfg_addr_e              i_cfg_addr,
	input  logic [ccd_pkg::CFG_DATA_W-1:0]  i_cfg_wdata,
	output logic                            o_cfg_ack,
	output logic [ccd_pkg::LLEN_W-1:0]      o_line_len,
	output logic [ccd_pkg::VCNT_W-1:0]      o_exp_lines,
	output logic [ccd_pkg::VCNT_W-1:0]      o_frame_period,
	output logic                            o_expo_en
);

	// accept only on the rising phase, req high while ack still low
	logic wr_en;

	assign wr_en = i_cfg_req && !o_cfg_ack;

	// ----------------------------------------------------------------------
	// handshake
	// ----------------------------------------------------------------------
	// ack follows req by one clock in both directions
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cfg_ack <= 1'b0;
		end else if (wr_en) begin
			o_cfg_ack <= 1'b1;
		end else if (!i_cfg_req) begin
			o_cfg_ack <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// register file
	// ----------------------------------------------------------------------
	// value lands on the same edge that raises ack
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_line_len     <= ccd_pkg::RST_LINE_LEN;
			o_exp_lines    <= ccd_pkg::RST_EXP_LINES;
			o_frame_period <= ccd_pkg::RST_FRAME_PERIOD;
			o_expo_en      <= 1'b0;
		end else if (wr_en) begin
			case (i_cfg_addr)
				ccd_pkg::REG_LINE_LEN: begin
					o_line_len <= i_cfg_wdata[ccd_pkg::LLEN_W-1:0];
				end
				ccd_pkg::REG_EXP_LINES: begin
					o_exp_lines <= i_cfg_wdata[ccd_pkg::VCNT_W-1:0];
				end
				ccd_pkg::REG_FRAME_PERIOD: begin
					o_frame_period <= i_cfg_wdata[ccd_pkg::VCNT_W-1:0];
				end
				ccd_pkg::REG_CTRL: begin
					// bit 0 arms the exposure cycle
					o_expo_en <= i_cfg_wdata[0];
				end
				default: begin
					o_expo_en <= o_expo_en;
				end
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	// host must wait for ack to drop before the next request
	a_req_no_rise_on_ack: assert property (
		@(posedge clk) disable iff (!i_rst_n)
		$rose(i_cfg_req) |-> !o_cfg_ack
	) else $error("cfg req rose while ack still high");

endmodule

//--- hw/ccd_timing_top.sv
// ccd vertical timing top with config registers, line timer, exposure and readout
module ccd_timing_top (
	input  logic                            clk,
	input  logic                            i_rst_n,
	// host write port
	input  logic                            i_cfg_req,
	input  ccd_pkg::cfg_addr_e              i_cfg_addr,
	input  logic [ccd_pkg::CFG_DATA_W-1:0]  i_cfg_wdata,
	output logic                            o_cfg_ack,
	// sensor side
	input  logic                            i_ccd_stop,
	output logic                            o_line_end,
	output logic                            o_xsg_flag,
	output logic                            o_readout_flag,
	output logic [ccd_pkg::VCNT_W-1:0]      o_vcount
);

	// ----------------------------------------------------------------------
	// configuration values
	// ----------------------------------------------------------------------
	logic [ccd_pkg::LLEN_W-1:0] line_len;
	logic [ccd_pkg::VCNT_W-1:0] exp_lines;
	logic [ccd_pkg::VCNT_W-1:0] frame_period;
	logic                       expo_en;

	// strobes and flags between the timing blocks
	ccd_timing_if tim ();

	ccd_regs u_regs (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_cfg_req      (i_cfg_req),
		.i_cfg_addr     (i_cfg_addr),
		.i_cfg_wdata    (i_cfg_wdata),
		.o_cfg_ack      (o_cfg_ack),
		.o_line_len     (line_len),
		.o_exp_lines    (exp_lines),
		.o_frame_period (frame_period),
		.o_expo_en      (expo_en)
	);

	ccd_line_timer u_line_timer (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_line_len (line_len),
		.tim        (tim)
	);

	ccd_exposure u_exposure (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_exp_lines (exp_lines),
		.i_expo_en   (expo_en),
		.tim         (tim)
	);

	ccd_readout u_readout (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_frame_period (frame_period),
		.i_ccd_stop     (i_ccd_stop),
		.tim            (tim),
		.o_vcount       (o_vcount)
	);

	// ----------------------------------------------------------------------
	// status out to the pins
	// ----------------------------------------------------------------------
	assign o_line_end     = tim.line_end;
	assign o_xsg_flag     = tim.xsg_flag;
	assign o_readout_flag = tim.readout_flag;

endmodule

//--- project.f
common/ccd_pkg.sv
common/ccd_timing_if.sv
hw/ccd_regs.sv
hw/ccd_line_timer.sv
ccd_readout/ccd_exposure.sv
ccd_readout/ccd_readout.sv
hw/ccd_timing_top.sv
verif/ccd_timing_checker.sv
verif/tb_ccd_timing.sv

//--- verif/ccd_timing_checker.sv
// reference model of the ccd vertical timing, compares the top-level ports each cycle
module ccd_timing_checker (
	input  logic                            clk,
	input  logic                            i_rst_n,
	input  logic                            i_cfg_req,
	input  ccd_pkg::cfg_addr_e              i_cfg_addr,
	input  logic [ccd_pkg::CFG_DATA_W-1:0]  i_cfg_wdata,
	input  logic                            i_cfg_ack,
	input  logic                            i_ccd_stop,
	input  logic                            i_line_end,
	input  logic                            i_xsg_flag,
	input  logic                            i_readout_flag,
	input  logic [ccd_pkg::VCNT_W-1:0]      i_vcount,
	input  int                              i_test_idx,
	input  logic                            i_test_done,
	input  logic                            i_all_done,
	output int                              o_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	// mirrored configuration and handshake
	bit m_ack;
	bit m_en;
	int m_len;
	int m_exp;
	int m_frame;
	// line in progress, length and clocks still to go
	int m_tlen;
	int m_left;
	// line ends seen in the current exposure
	int m_ecnt;
	ccd_pkg::seq_state_e m_state;
	bit m_xsg;
	bit m_ro;
	int m_vcnt;
	bit m_stop_d;

	// run and per-test bookkeeping
	int checks = 0;
	int errors = 0;
	int tests = 0;
	int tests_failed = 0;
	int t_checks = 0;
	int t_errs = 0;
	int t_lines = 0;
	int t_frames = 0;
	bit ro_seen = 1'b0;

	assign o_errors = errors;

	// ----------------------------------------------------------------------
	// model, advanced on the rising edge
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		bit le;
		bit ee;
		bit stop_rise;
		int eff_len;
		int eff_exp;
		ccd_pkg::seq_state_e nxt;
		if (!i_rst_n) begin
			m_ack    = 1'b0;
			m_en     = 1'b0;
			m_len    = 16;
			m_exp    = 3;
			m_frame  = 8;
			m_tlen   = 16;
			m_left   = 16;
			m_ecnt   = 0;
			m_state  = ccd_pkg::S_IDLE;
			m_xsg    = 1'b0;
			m_ro     = 1'b0;
			m_vcnt   = 0;
			m_stop_d = 1'b0;
		end else begin
			// strobes of the cycle closing at this edge
			le = (m_left == 1);
			eff_exp = (m_exp == 0) ? 1 : m_exp;
			ee = m_en && !m_ro && le && (m_ecnt + 1 >= eff_exp);
			stop_rise = i_ccd_stop && !m_stop_d;
			nxt = m_state;
			case (m_state)
				ccd_pkg::S_IDLE: begin
					if (ee) begin
						nxt = ccd_pkg::S_XSG;
					end
				end
				ccd_pkg::S_XSG: begin
					if (le && m_vcnt == ccd_pkg::XSG_LINE_NUM - 1) begin
						nxt = ccd_pkg::S_READOUT;
					end
				end
				ccd_pkg::S_READOUT: begin
					if ((le && m_vcnt == m_frame) || stop_rise) begin
						nxt = ccd_pkg::S_IDLE;
					end
				end
				default: begin
					nxt = ccd_pkg::S_IDLE;
				end
			endcase
			// exposure count, cleared while readout runs or disarmed
			if (!m_en || m_ro) begin
				m_ecnt = 0;
			end else if (le) begin
				m_ecnt = ee ? 0 : m_ecnt + 1;
			end
			// line count follows the old state
			if (m_state == ccd_pkg::S_IDLE) begin
				m_vcnt = 0;
			end else if (le) begin
				m_vcnt = m_vcnt + 1;
			end
			m_xsg = (m_state == ccd_pkg::S_XSG);
			m_ro = (m_state != ccd_pkg::S_IDLE);
			m_state = nxt;
			// timer sees the register value from before this edge
			eff_len = (m_len < 4) ? 4 : m_len;
			if (eff_len != m_tlen) begin
				m_tlen = eff_len;
				m_left = eff_len;
			end else if (le) begin
				m_left = m_tlen;
			end else begin
				m_left = m_left - 1;
			end
			// one write per handshake, on the rising phase
			if (i_cfg_req && !m_ack) begin
				m_ack = 1'b1;
				case (i_cfg_addr)
					ccd_pkg::REG_LINE_LEN: m_len = int'(i_cfg_wdata[ccd_pkg::LLEN_W-1:0]);
					ccd_pkg::REG_EXP_LINES: m_exp = int'(i_cfg_wdata[ccd_pkg::VCNT_W-1:0]);
					ccd_pkg::REG_FRAME_PERIOD: m_frame = int'(i_cfg_wdata[ccd_pkg::VCNT_W-1:0]);
					default: m_en = i_cfg_wdata[0];
				endcase
			end else if (!i_cfg_req) begin
				m_ack = 1'b0;
			end
			m_stop_d = i_ccd_stop;
		end
	end

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		t_checks++;
		if (act_v !== exp_v) begin
			errors++;
			t_errs++;
			$display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	// ----------------------------------------------------------------------
	// compare mid-cycle, outputs settled
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (i_rst_n) begin
			check_value("o_cfg_ack", 32'(m_ack), 32'(i_cfg_ack));
			check_value("o_line_end", 32'(m_left == 1), 32'(i_line_end));
			check_value("o_xsg_flag", 32'(m_xsg), 32'(i_xsg_flag));
			check_value("o_readout_flag", 32'(m_ro), 32'(i_readout_flag));
			check_value("o_vcount", 32'(m_vcnt), 32'(i_vcount));
			if (i_line_end) begin
				t_lines++;
			end
			if (ro_seen && !i_readout_flag) begin
				t_frames++;
			end
			ro_seen = i_readout_flag;
		end
		if (i_test_done) begin
			if (t_frames == 0) begin
				errors++;
				t_errs++;
				$display("test %0d finished without a completed frame", i_test_idx);
			end
			tests++;
			if (t_errs != 0) begin
				tests_failed++;
			end
			$display("test %0d: %0d line ends, %0d frames, %0d checks, %0d errors, %s",
				i_test_idx, t_lines, t_frames, t_checks, t_errs,
				(t_errs == 0) ? "pass" : "FAIL");
			t_checks = 0;
			t_errs = 0;
			t_lines = 0;
			t_frames = 0;
		end
		if (i_all_done) begin
			$display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
				tests, tests - tests_failed, tests_failed, checks, errors);
		end
	end

endmodule

//--- verif/tb_ccd_timing.sv
// testbench for the ccd vertical timing with seeded random configurations and stops
module tb_ccd_timing;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 8;
	localparam int MAX_LINE = 20;
	localparam int MAX_EXP = 5;
	localparam int MAX_FRAME = 12;
	// exposure plus partial line plus all frame lines, then six writes and two short lines
	localparam int WORST_TEST = MAX_LINE * (MAX_EXP + MAX_FRAME + 2) + 6 * 4 + 2 * 4;
	localparam int CYCLE_LIMIT = 2 * NUM_TESTS * WORST_TEST;

	logic clk = 1'b0;
	logic rst_n;
	logic cfg_req;
	ccd_pkg::cfg_addr_e cfg_addr;
	logic [ccd_pkg::CFG_DATA_W-1:0] cfg_wdata;
	logic cfg_ack;
	logic ccd_stop;
	logic line_end;
	logic xsg_flag;
	logic readout_flag;
	logic [ccd_pkg::VCNT_W-1:0] vcount;

	// test bookkeeping toward the checker
	int test_idx;
	logic test_done;
	logic all_done;
	int errors;
	int cycles = 0;

	always #5 clk = ~clk;

	ccd_timing_top UUT (
		.clk            (clk),
		.i_rst_n        (rst_n),
		.i_cfg_req      (cfg_req),
		.i_cfg_addr     (cfg_addr),
		.i_cfg_wdata    (cfg_wdata),
		.o_cfg_ack      (cfg_ack),
		.i_ccd_stop     (ccd_stop),
		.o_line_end     (line_end),
		.o_xsg_flag     (xsg_flag),
		.o_readout_flag (readout_flag),
		.o_vcount       (vcount)
	);

	ccd_timing_checker u_checker (
		.clk            (clk),
		.i_rst_n        (rst_n),
		.i_cfg_req      (cfg_req),
		.i_cfg_addr     (cfg_addr),
		.i_cfg_wdata    (cfg_wdata),
		.i_cfg_ack      (cfg_ack),
		.i_ccd_stop     (ccd_stop),
		.i_line_end     (line_end),
		.i_xsg_flag     (xsg_flag),
		.i_readout_flag (readout_flag),
		.i_vcount       (vcount),
		.i_test_idx     (test_idx),
		.i_test_done    (test_done),
		.i_all_done     (all_done),
		.o_errors       (errors)
	);

	// ----------------------------------------------------------------------
	// helpers, all return 1 ns after a rising edge
	// ----------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// full four-phase write
	task automatic cfg_write(input ccd_pkg::cfg_addr_e addr,
		input logic [ccd_pkg::CFG_DATA_W-1:0] data);
		cfg_addr = addr;
		cfg_wdata = data;
		cfg_req = 1'b1;
		do next_cycle(); while (!cfg_ack);
		cfg_req = 1'b0;
		do next_cycle(); while (cfg_ack);
	endtask

	task automatic wait_xsg(input logic level);
		while (xsg_flag !== level) next_cycle();
	endtask

	task automatic wait_readout(input logic level);
		while (readout_flag !== level) next_cycle();
	endtask

	// let a number of line strobes go by
	task automatic wait_line_ends(input int num);
		int seen;
		seen = 0;
		while (seen < num) begin
			next_cycle();
			if (line_end) begin
				seen++;
			end
		end
	endtask

	task automatic pulse_stop();
		ccd_stop = 1'b1;
		next_cycle();
		next_cycle();
		ccd_stop = 1'b0;
	endtask

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		int llen;
		int elines;
		int fperiod;
		int mode;
		int delay;
		void'($urandom(32'h55f9));
		rst_n = 1'b0;
		cfg_req = 1'b0;
		cfg_addr = ccd_pkg::REG_LINE_LEN;
		cfg_wdata = '0;
		ccd_stop = 1'b0;
		test_idx = 0;
		test_done = 1'b0;
		all_done = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) begin
			test_idx = t;
			llen = $urandom_range(MAX_LINE, 4);
			elines = $urandom_range(MAX_EXP, 1);
			fperiod = $urandom_range(MAX_FRAME, ccd_pkg::XSG_LINE_NUM + 1);
			// 0 stop while idle, 1 stop in readout, 2 stop in xsg
			mode = $urandom_range(2, 0);
			if (mode == 0) begin
				pulse_stop();
			end
			// sometimes a too short line first, clamped to 4
			if ($urandom_range(3, 0) == 0) begin
				cfg_write(ccd_pkg::REG_LINE_LEN, ccd_pkg::CFG_DATA_W'($urandom_range(3, 0)));
				wait_line_ends(2);
			end
			cfg_write(ccd_pkg::REG_LINE_LEN, ccd_pkg::CFG_DATA_W'(llen));
			cfg_write(ccd_pkg::REG_EXP_LINES, ccd_pkg::CFG_DATA_W'(elines));
			cfg_write(ccd_pkg::REG_FRAME_PERIOD, ccd_pkg::CFG_DATA_W'(fperiod));
			cfg_write(ccd_pkg::REG_CTRL, ccd_pkg::CFG_DATA_W'(1));
			wait_xsg(1'b1);
			if (mode == 2) begin
				pulse_stop();
			end
			wait_xsg(1'b0);
			if (mode == 1) begin
				delay = $urandom_range(llen * fperiod, 1);
				while (delay > 0 && readout_flag) begin
					next_cycle();
					delay--;
				end
				if (readout_flag) begin
					pulse_stop();
				end
			end
			wait_readout(1'b0);
			// disarm so the next configuration starts from idle
			cfg_write(ccd_pkg::REG_CTRL, ccd_pkg::CFG_DATA_W'(0));
			test_done = 1'b1;
			next_cycle();
			test_done = 1'b0;
		end
		all_done = 1'b1;
		next_cycle();
		all_done = 1'b0;
		next_cycle();
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
